/* verilog/mips_macros.svh */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Architectural sizes of the MIPS register file.
////////////////////////////////////////////////////////////////////////////

// Number of general purpose registers.
`define MIPS_REG_COUNT 32

// Width of one register and of the data paths.
`define MIPS_DATA_WIDTH 32

// Register address width, enough for MIPS_REG_COUNT.
`define MIPS_REG_ADDR_WIDTH 5

// Immediate field of the I-type format.
`define MIPS_IMM_WIDTH 16

`endif

/* verilog/mips_pkg.sv */
`include "mips_macros.svh"

package mips_pkg;

    // Primary opcodes handled by the decode stage.
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_addi    = 6'h08,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // R-type layout with the opcode in the top six bits.
    typedef struct packed {
        opcode_e                          opcode;
        logic [`MIPS_REG_ADDR_WIDTH-1:0]  rs;
        logic [`MIPS_REG_ADDR_WIDTH-1:0]  rt;
        logic [`MIPS_REG_ADDR_WIDTH-1:0]  rd;
        logic [4:0]                       shamt;
        logic [5:0]                       funct;
    } instr_r_t;

    // I-type layout.
    typedef struct packed {
        opcode_e                          opcode;
        logic [`MIPS_REG_ADDR_WIDTH-1:0]  rs;
        logic [`MIPS_REG_ADDR_WIDTH-1:0]  rt;
        logic [`MIPS_IMM_WIDTH-1:0]       imm;
    } instr_i_t;

    // One instruction word, seen through either format.
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

endpackage

/* verilog/register_file.sv */
`timescale 1ns/100ps

`include "mips_macros.svh"

module register_file (
    input  logic                            i_clock,
    input  logic                            i_soft_reset,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] i_read_addr_a,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] i_read_addr_b,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] i_debug_addr,
    input  logic                            i_write_enable,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] i_write_addr,
    input  logic [`MIPS_DATA_WIDTH-1:0]     i_write_data,
    output logic [`MIPS_DATA_WIDTH-1:0]     o_data_a,
    output logic [`MIPS_DATA_WIDTH-1:0]     o_data_b,
    output logic [`MIPS_DATA_WIDTH-1:0]     o_debug_data,
    output logic                            o_led
);

    // Architectural registers.
    logic [`MIPS_DATA_WIDTH-1:0] registers [0:`MIPS_REG_COUNT-1];

    ////////////////////////////////////////////////////////////////////////////
    // Write port on the falling edge.
    ////////////////////////////////////////////////////////////////////////////

    // Writing at the falling edge lets a read at the following rising
    // edge see the new value.
    always_ff @(negedge i_clock) begin
        if (!i_soft_reset) begin
            for (int idx = 0; idx < `MIPS_REG_COUNT; idx++) begin
                registers[idx] <= '0;
            end
        end else if (i_write_enable && (i_write_addr != '0)) begin
            // Register 0 stays hardwired to zero.
            registers[i_write_addr] <= i_write_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read ports on the rising edge.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            o_data_a     <= '0;
            o_data_b     <= '0;
            o_debug_data <= '0;
        end else begin
            o_data_a     <= registers[i_read_addr_a];
            o_data_b     <= registers[i_read_addr_b];
            o_debug_data <= registers[i_debug_addr];
        end
    end

    // Status level for register 1.
    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            o_led <= 1'b0;
        end else begin
            o_led <= (registers[1] != '0);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks.
    ////////////////////////////////////////////////////////////////////////////

    // A strobed write must name a known register at the edge that stores it.
    write_addr_known: assert property (
        @(negedge i_clock) disable iff (!i_soft_reset)
        i_write_enable |-> !$isunknown(i_write_addr)
    ) else $error("register_file: write address unknown while write enabled.");

endmodule

/* verilog/instruction_decoder.sv */
`timescale 1ns/100ps

`include "mips_macros.svh"

module instruction_decoder (
    input  logic                            i_clock,
    input  logic                            i_soft_reset,
    input  mips_pkg::instr_u                i_instruction,
    output logic [`MIPS_REG_ADDR_WIDTH-1:0] o_rs_addr,
    output logic [`MIPS_REG_ADDR_WIDTH-1:0] o_rt_addr,
    output logic [`MIPS_REG_ADDR_WIDTH-1:0] o_write_reg,
    output logic [`MIPS_DATA_WIDTH-1:0]     o_imm,
    output logic [5:0]                      o_funct,
    output logic [4:0]                      o_shamt,
    output logic                            o_reg_write,
    output logic                            o_alu_src_imm,
    output logic                            o_mem_read,
    output logic                            o_mem_write,
    output logic                            o_illegal
);

    localparam int EXT_WIDTH = `MIPS_DATA_WIDTH - `MIPS_IMM_WIDTH;

    mips_pkg::opcode_e               opcode;
    logic                            is_r_type;
    logic [`MIPS_IMM_WIDTH-1:0]      imm_field;
    logic [`MIPS_REG_ADDR_WIDTH-1:0] next_write_reg;
    logic [`MIPS_DATA_WIDTH-1:0]     next_imm;
    logic [5:0]                      next_funct;
    logic [4:0]                      next_shamt;
    logic                            next_reg_write;
    logic                            next_alu_src_imm;
    logic                            next_mem_read;
    logic                            next_mem_write;
    logic                            next_illegal;

    assign opcode    = i_instruction.r.opcode;
    assign is_r_type = (opcode == mips_pkg::op_special);
    assign imm_field = i_instruction.i.imm;

    // Source addresses go straight to the register file.
    // The rs and rt fields sit at the same bits in both formats.
    assign o_rs_addr = i_instruction.i.rs;
    assign o_rt_addr = i_instruction.i.rt;

    ////////////////////////////////////////////////////////////////////////////
    // Field decode.
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        next_write_reg = is_r_type ? i_instruction.r.rd : i_instruction.i.rt;
        next_funct     = is_r_type ? i_instruction.r.funct : 6'd0;
        next_shamt     = is_r_type ? i_instruction.r.shamt : 5'd0;

        // Logical immediates are unsigned and lui fills the upper half.
        case (opcode)
            mips_pkg::op_andi,
            mips_pkg::op_ori,
            mips_pkg::op_xori: next_imm = {{EXT_WIDTH{1'b0}}, imm_field};
            mips_pkg::op_lui:  next_imm = {imm_field, {EXT_WIDTH{1'b0}}};
            default:           next_imm = {{EXT_WIDTH{imm_field[`MIPS_IMM_WIDTH-1]}}, imm_field};
        endcase
    end

    // Control table.
    always_comb begin
        next_reg_write   = 1'b0;
        next_alu_src_imm = 1'b0;
        next_mem_read    = 1'b0;
        next_mem_write   = 1'b0;
        next_illegal     = 1'b0;
        case (opcode)
            mips_pkg::op_special: next_reg_write = 1'b1;
            mips_pkg::op_addi,
            mips_pkg::op_addiu,
            mips_pkg::op_slti,
            mips_pkg::op_andi,
            mips_pkg::op_ori,
            mips_pkg::op_xori,
            mips_pkg::op_lui: begin
                next_reg_write   = 1'b1;
                next_alu_src_imm = 1'b1;
            end
            mips_pkg::op_lw: begin
                next_reg_write   = 1'b1;
                next_alu_src_imm = 1'b1;
                next_mem_read    = 1'b1;
            end
            mips_pkg::op_sw: begin
                next_alu_src_imm = 1'b1;
                next_mem_write   = 1'b1;
            end
            // Branches, jumps and the rest.
            default: next_illegal = 1'b1;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // ID/EX register, aligned with the register file read.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            o_write_reg   <= '0;
            o_imm         <= '0;
            o_funct       <= '0;
            o_shamt       <= '0;
            o_reg_write   <= 1'b0;
            o_alu_src_imm <= 1'b0;
            o_mem_read    <= 1'b0;
            o_mem_write   <= 1'b0;
            o_illegal     <= 1'b0;
        end else begin
            o_write_reg   <= next_write_reg;
            o_imm         <= next_imm;
            o_funct       <= next_funct;
            o_shamt       <= next_shamt;
            o_reg_write   <= next_reg_write;
            o_alu_src_imm <= next_alu_src_imm;
            o_mem_read    <= next_mem_read;
            o_mem_write   <= next_mem_write;
            o_illegal     <= next_illegal;
        end
    end

    // A store never writes back.
    store_no_writeback: assert property (
        @(posedge i_clock) disable iff (!i_soft_reset)
        !(o_reg_write && o_mem_write)
    ) else $error("instruction_decoder: reg_write and mem_write both high.");

    // Illegal words carry no controls into execute.
    illegal_no_controls: assert property (
        @(posedge i_clock) disable iff (!i_soft_reset)
        o_illegal |-> !(o_reg_write || o_alu_src_imm || o_mem_read || o_mem_write)
    ) else $error("instruction_decoder: control raised on an illegal word.");

endmodule

/* verilog/decode_stage.sv */
`timescale 1ns/100ps

`include "mips_macros.svh"

module decode_stage (
    input  logic                            i_clock,
    input  logic                            i_soft_reset,
    input  mips_pkg::instr_u                i_instruction,
    input  logic                            i_wb_enable,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] i_wb_addr,
    input  logic [`MIPS_DATA_WIDTH-1:0]     i_wb_data,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] i_debug_addr,
    output logic [`MIPS_DATA_WIDTH-1:0]     o_data_a,
    output logic [`MIPS_DATA_WIDTH-1:0]     o_data_b,
    output logic [`MIPS_DATA_WIDTH-1:0]     o_debug_data,
    output logic [`MIPS_DATA_WIDTH-1:0]     o_imm,
    output logic [`MIPS_REG_ADDR_WIDTH-1:0] o_write_reg,
    output logic [5:0]                      o_funct,
    output logic [4:0]                      o_shamt,
    output logic                            o_reg_write,
    output logic                            o_alu_src_imm,
    output logic                            o_mem_read,
    output logic                            o_mem_write,
    output logic                            o_illegal,
    output logic                            o_led
);

    // Source register addresses, decoder to register file.
    logic [`MIPS_REG_ADDR_WIDTH-1:0] rs_addr;
    logic [`MIPS_REG_ADDR_WIDTH-1:0] rt_addr;

    instruction_decoder u_decoder (
        .i_clock       (i_clock),
        .i_soft_reset  (i_soft_reset),
        .i_instruction (i_instruction),
        .o_rs_addr     (rs_addr),
        .o_rt_addr     (rt_addr),
        .o_write_reg   (o_write_reg),
        .o_imm         (o_imm),
        .o_funct       (o_funct),
        .o_shamt       (o_shamt),
        .o_reg_write   (o_reg_write),
        .o_alu_src_imm (o_alu_src_imm),
        .o_mem_read    (o_mem_read),
        .o_mem_write   (o_mem_write),
        .o_illegal     (o_illegal)
    );

    // Writeback enters here from outside the stage.
    register_file u_register_file (
        .i_clock        (i_clock),
        .i_soft_reset   (i_soft_reset),
        .i_read_addr_a  (rs_addr),
        .i_read_addr_b  (rt_addr),
        .i_debug_addr   (i_debug_addr),
        .i_write_enable (i_wb_enable),
        .i_write_addr   (i_wb_addr),
        .i_write_data   (i_wb_data),
        .o_data_a       (o_data_a),
        .o_data_b       (o_data_b),
        .o_debug_data   (o_debug_data),
        .o_led          (o_led)
    );

endmodule

/* tests/decode_stage_tb.sv */
`timescale 1ns/100ps

`include "mips_macros.svh"

module decode_stage_tb;

    localparam int NUM_COLS  = 14;
    localparam int MAX_ROWS  = 64;
    // Extra row of zeros for the outputs expected in reset.
    localparam int RESET_ROW = MAX_ROWS;

    logic                            i_clock;
    logic                            i_soft_reset;
    mips_pkg::instr_u                i_instruction;
    logic                            i_wb_enable;
    logic [`MIPS_REG_ADDR_WIDTH-1:0] i_wb_addr;
    logic [`MIPS_DATA_WIDTH-1:0]     i_wb_data;
    logic [`MIPS_REG_ADDR_WIDTH-1:0] i_debug_addr;
    logic [`MIPS_DATA_WIDTH-1:0]     o_data_a;
    logic [`MIPS_DATA_WIDTH-1:0]     o_data_b;
    logic [`MIPS_DATA_WIDTH-1:0]     o_debug_data;
    logic [`MIPS_DATA_WIDTH-1:0]     o_imm;
    logic [`MIPS_REG_ADDR_WIDTH-1:0] o_write_reg;
    logic [5:0]                      o_funct;
    logic [4:0]                      o_shamt;
    logic                            o_reg_write;
    logic                            o_alu_src_imm;
    logic                            o_mem_read;
    logic                            o_mem_write;
    logic                            o_illegal;
    logic                            o_led;

    // Inputs in columns 0 to 4 and expected outputs in columns 5 to 13.
    logic [31:0] rows [0:MAX_ROWS][0:NUM_COLS-1];
    int          row_count;
    int          cycle_count;
    int          cycle_limit;
    int          mismatch_count;
    int          other_errors;

    decode_stage dut0 (.*);

    initial begin
        i_clock = 1'b0;
        forever #20 i_clock = ~i_clock;
    end

    // Watchdog on rising edges.
    initial begin
        cycle_count = 0;
        while (cycle_count <= cycle_limit) begin
            @(posedge i_clock);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("TB FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus file and checks.
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_stimulus();
        int    fd;
        int    fields;
        string text;
        row_count = 0;
        fd = $fopen("tests/decode_stage_stimulus.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open tests/decode_stage_stimulus.txt");
            other_errors++;
            return;
        end
        while (row_count < MAX_ROWS && $fgets(text, fd) != 0) begin
            // Lines starting with a hash are comments.
            if (text.len() > 1 && text[0] != "#") begin
                fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    rows[row_count][0], rows[row_count][1], rows[row_count][2],
                    rows[row_count][3], rows[row_count][4], rows[row_count][5],
                    rows[row_count][6], rows[row_count][7], rows[row_count][8],
                    rows[row_count][9], rows[row_count][10], rows[row_count][11],
                    rows[row_count][12], rows[row_count][13]);
                if (fields == NUM_COLS) begin
                    row_count++;
                end else begin
                    $display("error: stimulus row %0d holds %0d of %0d fields",
                             row_count + 1, fields, NUM_COLS);
                    other_errors++;
                end
            end
        end
        $fclose(fd);
        if (row_count == 0) begin
            $display("error: stimulus file holds no rows");
            other_errors++;
        end
    endtask

    task automatic apply_row(input int idx);
        i_instruction = rows[idx][0];
        i_wb_enable   = rows[idx][1][0];
        i_wb_addr     = rows[idx][2][`MIPS_REG_ADDR_WIDTH-1:0];
        i_wb_data     = rows[idx][3];
        i_debug_addr  = rows[idx][4][`MIPS_REG_ADDR_WIDTH-1:0];
    endtask

    task automatic compare_value(input string name, input string where,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("mismatch %s at %s: expected %h, actual %h", name, where, expected, actual);
        end
    endtask

    task automatic check_outputs(input int idx, input string where);
        compare_value("o_data_a", where, rows[idx][5], o_data_a);
        compare_value("o_data_b", where, rows[idx][6], o_data_b);
        compare_value("o_debug_data", where, rows[idx][7], o_debug_data);
        compare_value("o_imm", where, rows[idx][8], o_imm);
        compare_value("o_write_reg", where, rows[idx][9], o_write_reg);
        compare_value("o_funct", where, rows[idx][10], o_funct);
        compare_value("o_shamt", where, rows[idx][11], o_shamt);
        // Control field bits run from reg_write at bit 4 down to illegal at bit 0.
        compare_value("o_reg_write", where, rows[idx][12][4], o_reg_write);
        compare_value("o_alu_src_imm", where, rows[idx][12][3], o_alu_src_imm);
        compare_value("o_mem_read", where, rows[idx][12][2], o_mem_read);
        compare_value("o_mem_write", where, rows[idx][12][1], o_mem_write);
        compare_value("o_illegal", where, rows[idx][12][0], o_illegal);
        compare_value("o_led", where, rows[idx][13], o_led);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence.
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        i_soft_reset   = 1'b0;
        i_instruction  = '0;
        i_wb_enable    = 1'b0;
        i_wb_addr      = '0;
        i_wb_data      = '0;
        i_debug_addr   = '0;
        mismatch_count = 0;
        other_errors   = 0;
        for (int col = 0; col < NUM_COLS; col++) begin
            rows[RESET_ROW][col] = '0;
        end
        load_stimulus();
        cycle_limit = 2 * row_count + 20;

        // Two rising edges in reset.
        repeat (2) @(posedge i_clock);
        #1;
        check_outputs(RESET_ROW, "reset");
        #1;
        i_soft_reset = 1'b1;

        // Each row is driven 2 ns after an edge and checked 1 ns after the next.
        for (int idx = 0; idx < row_count; idx++) begin
            apply_row(idx);
            @(posedge i_clock);
            #1;
            check_outputs(idx, $sformatf("row %0d", idx + 1));
            #1;
        end

        $display("rows: %0d, mismatches: %0d, other errors: %0d",
                 row_count, mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+verilog
verilog/mips_pkg.sv
verilog/register_file.sv
verilog/instruction_decoder.sv
verilog/decode_stage.sv
tests/decode_stage_tb.sv

/* Bender.yml */
package:
  name: mips_decode_stage

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mips_pkg.sv
      - verilog/register_file.sv
      - verilog/instruction_decoder.sv
      - verilog/decode_stage.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/decode_stage_tb.sv

/* tests/decode_stage_stimulus.txt */
# instr wb_en wb_addr wb_data debug_addr, then expected after the next edge:
# data_a data_b debug_data imm write_reg funct shamt controls(rw,alu_imm,mrd,mwr,ill) led
00000000 0 00 00000000 05 00000000 00000000 00000000 00000000 00 00 00 10 0
00000000 0 00 00000000 1f 00000000 00000000 00000000 00000000 00 00 00 10 0
00000000 0 00 00000000 01 00000000 00000000 00000000 00000000 00 00 00 10 0
# Writes seen in the same cycle and later.
00000000 1 02 deadbeef 00 00000000 00000000 00000000 00000000 00 00 00 10 0
00000000 1 03 0badf00d 02 00000000 00000000 deadbeef 00000000 00 00 00 10 0
00000000 1 04 80000001 03 00000000 00000000 0badf00d 00000000 00 00 00 10 0
# R-type, then a write to register 0.
00432820 0 00 00000000 04 deadbeef 0badf00d 80000001 00002820 05 20 00 10 0
00a430c3 1 05 5555aaaa 05 5555aaaa 80000001 5555aaaa 000030c3 06 03 03 10 0
00023825 1 00 ffffffff 00 00000000 deadbeef 00000000 00003825 07 25 00 10 0
00000000 0 00 00000000 00 00000000 00000000 00000000 00000000 00 00 00 10 0
# I-type immediates.
2048fff0 0 00 00000000 02 deadbeef 00000000 deadbeef fffffff0 08 00 00 18 0
34698001 1 09 00000099 09 0badf00d 00000099 00000099 00008001 09 00 00 18 0
308af0f0 0 00 00000000 04 80000001 00000000 80000001 0000f0f0 0a 00 00 18 0
380babcd 0 00 00000000 00 00000000 00000000 00000000 0000abcd 0b 00 00 18 0
3c0c8765 0 00 00000000 00 00000000 00000000 00000000 87650000 0c 00 00 18 0
24ad7fff 0 00 00000000 05 5555aaaa 00000000 5555aaaa 00007fff 0d 00 00 18 0
28438000 0 00 00000000 03 deadbeef 0badf00d 0badf00d ffff8000 03 00 00 18 0
# Load, store, branches and a jump.
8c4e0010 0 00 00000000 0e deadbeef 00000000 00000000 00000010 0e 00 00 1c 0
ac83fffc 0 00 00000000 00 80000001 0badf00d 00000000 fffffffc 03 00 00 0a 0
10430004 0 00 00000000 00 deadbeef 0badf00d 00000000 00000004 03 00 00 01 0
08000040 0 00 00000000 00 00000000 00000000 00000000 00000040 00 00 00 01 0
14a9fffe 0 00 00000000 09 5555aaaa 00000099 00000099 fffffffe 09 00 00 01 0
# Register 1 and the status level.
00000000 1 01 00000001 01 00000000 00000000 00000001 00000000 00 00 00 10 1
00210820 1 01 80000000 01 80000000 80000000 80000000 00000820 01 20 00 10 1
00000000 1 01 00000000 01 00000000 00000000 00000000 00000000 00 00 00 10 0
00000000 0 00 00000000 02 00000000 00000000 deadbeef 00000000 00 00 00 10 0
# Top register, then a write left disabled.
03e0f808 1 1f cafe0031 1f cafe0031 00000000 cafe0031 fffff808 1f 08 00 10 0
00000000 0 02 11111111 02 00000000 00000000 deadbeef 00000000 00 00 00 10 0
